// File: hw/rs_pkg.sv
/* Sizes and shared types of the reservation station.
   An operand with its valid bit low carries a prf_tag_t in its low bits. */
package rs_pkg;

	localparam int RS_SIZE   = 8;
	localparam int PRF_SIZE  = 64;
	localparam int ROB_SIZE  = 32;
	localparam int FU_PORTS  = 6;
	localparam int TAG_W     = $clog2(PRF_SIZE);
	localparam int ROB_W     = $clog2(ROB_SIZE);
	localparam int WORD_W    = 64;
	localparam int OP_TYPE_W = 6;

	typedef logic [TAG_W-1:0]     prf_tag_t;
	typedef logic [ROB_W-1:0]     rob_idx_t;
	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [OP_TYPE_W-1:0] op_type_t;
	typedef logic [RS_SIZE-1:0]   rs_vec_t;

	typedef enum logic [4:0] {
		alu_default,
		alu_addq,
		alu_subq,
		alu_and,
		alu_bic,
		alu_bis,
		alu_ornot,
		alu_xor,
		alu_eqv,
		alu_srl,
		alu_sll,
		alu_sra,
		alu_mulq,
		alu_cmpeq,
		alu_cmplt,
		alu_cmple,
		alu_cmpult,
		alu_cmpule
	} alu_func_t;

	typedef enum logic [1:0] {
		use_adder,
		use_multiplier,
		use_memory
	} fu_class_t;

	typedef enum logic [1:0] {
		no_entry_empty,
		one_entry_empty,
		two_or_more_empty
	} rs_full_t;

	typedef enum logic [1:0] {
		entry_free,
		entry_waiting,
		entry_ready
	} rs_entry_state_t;

	// Unit class served by each issue port, lane 1 then lane 2
	localparam fu_class_t PORT_CLASS [FU_PORTS] = '{
		use_multiplier, use_adder, use_memory,
		use_multiplier, use_adder, use_memory
	};

endpackage

// File: hw/rs_dispatch_bypass.sv
`timescale 1ns/100ps
/* Purely combinational. A result broadcast in the dispatch cycle is folded into tag operands. */
module rs_dispatch_bypass import rs_pkg::*; (
	input  word_t     inst1_opa,
	input  logic      inst1_opa_valid,
	input  word_t     inst1_opb,
	input  logic      inst1_opb_valid,
	input  op_type_t  inst1_op_type,
	input  alu_func_t inst1_alu_func,
	input  word_t     inst2_opa,
	input  logic      inst2_opa_valid,
	input  word_t     inst2_opb,
	input  logic      inst2_opb_valid,
	input  op_type_t  inst2_op_type,
	input  alu_func_t inst2_alu_func,
	input  logic      cdb1_valid,
	input  prf_tag_t  cdb1_tag,
	input  word_t     cdb1_value,
	input  logic      cdb2_valid,
	input  prf_tag_t  cdb2_tag,
	input  word_t     cdb2_value,
	output word_t     inst1_opa_fwd,
	output logic      inst1_opa_fwd_valid,
	output word_t     inst1_opb_fwd,
	output logic      inst1_opb_fwd_valid,
	output fu_class_t inst1_class,
	output word_t     inst2_opa_fwd,
	output logic      inst2_opa_fwd_valid,
	output word_t     inst2_opb_fwd,
	output logic      inst2_opb_fwd_valid,
	output fu_class_t inst2_class
);

	// Returns {valid, value}, CDB1 checked first
	function automatic logic [WORD_W:0] forward(word_t op, logic op_valid);
		if (!op_valid && cdb1_valid && cdb1_tag == op[TAG_W-1:0])
			return {1'b1, cdb1_value};
		if (!op_valid && cdb2_valid && cdb2_tag == op[TAG_W-1:0])
			return {1'b1, cdb2_value};
		return {op_valid, op};
	endfunction

	// Unit class from major opcode group
	function automatic fu_class_t decode_class(op_type_t op_type, alu_func_t alu_func);
		if (op_type[5:3] == 3'd2 && alu_func == alu_mulq)
			return use_multiplier;
		if (op_type[5:3] == 3'd4 || op_type[5:3] == 3'd5)
			return use_memory; // Loads and stores
		return use_adder;
	endfunction

	always_comb begin
		{inst1_opa_fwd_valid, inst1_opa_fwd} = forward(inst1_opa, inst1_opa_valid);
		{inst1_opb_fwd_valid, inst1_opb_fwd} = forward(inst1_opb, inst1_opb_valid);
		{inst2_opa_fwd_valid, inst2_opa_fwd} = forward(inst2_opa, inst2_opa_valid);
		{inst2_opb_fwd_valid, inst2_opb_fwd} = forward(inst2_opb, inst2_opb_valid);
		inst1_class = decode_class(inst1_op_type, inst1_alu_func);
		inst2_class = decode_class(inst2_op_type, inst2_alu_func);
	end

endmodule

// File: hw/rs_entry.sv
`timescale 1ns/100ps
/* One station slot. A load is only expected while the slot is free.
   A waiting slot captures CDB results, and a ready slot holds until issue. */
module rs_entry import rs_pkg::*; (
	input  logic      clock,
	input  logic      arst_n,
	input  logic      load,
	input  word_t     opa,
	input  logic      opa_valid,
	input  word_t     opb,
	input  logic      opb_valid,
	input  prf_tag_t  dest,
	input  op_type_t  op_type,
	input  alu_func_t alu_func,
	input  rob_idx_t  rob_idx,
	input  fu_class_t fu_class,
	input  logic      issue,
	input  logic      cdb1_valid,
	input  prf_tag_t  cdb1_tag,
	input  word_t     cdb1_value,
	input  logic      cdb2_valid,
	input  prf_tag_t  cdb2_tag,
	input  word_t     cdb2_value,
	output logic      free,
	output logic      ready,
	output word_t     opa_out,
	output word_t     opb_out,
	output prf_tag_t  dest_out,
	output op_type_t  op_type_out,
	output alu_func_t alu_func_out,
	output rob_idx_t  rob_idx_out,
	output fu_class_t class_out
);

	rs_entry_state_t state;
	word_t           opa_q;
	word_t           opb_q;
	logic            opa_valid_q;
	logic            opb_valid_q;
	word_t           opa_snoop;
	word_t           opb_snoop;
	logic            opa_snoop_valid;
	logic            opb_snoop_valid;

	// Snoop of a held operand, CDB1 wins on a double match
	function automatic logic [WORD_W:0] snoop(word_t op, logic op_valid);
		if (!op_valid && cdb1_valid && cdb1_tag == op[TAG_W-1:0])
			return {1'b1, cdb1_value};
		if (!op_valid && cdb2_valid && cdb2_tag == op[TAG_W-1:0])
			return {1'b1, cdb2_value};
		return {op_valid, op};
	endfunction

	always_comb begin
		{opa_snoop_valid, opa_snoop} = snoop(opa_q, opa_valid_q);
		{opb_snoop_valid, opb_snoop} = snoop(opb_q, opb_valid_q);
	end

	////////////////////////////////////////////////////////////
	// Slot FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state       <= entry_free;
			opa_valid_q <= 1'b0;
			opb_valid_q <= 1'b0;
		end else begin
			case (state)
				entry_free: if (load) begin
					opa_valid_q <= opa_valid;
					opb_valid_q <= opb_valid;
					state       <= (opa_valid && opb_valid) ? entry_ready : entry_waiting;
				end
				entry_waiting: begin
					opa_valid_q <= opa_snoop_valid;
					opb_valid_q <= opb_snoop_valid;
					if (opa_snoop_valid && opb_snoop_valid)
						state <= entry_ready;
				end
				entry_ready: if (issue)
					state <= entry_free;
				default: state <= entry_free;
			endcase
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		if (state == entry_free && load) begin
			opa_q     <= opa;
			opb_q     <= opb;
			dest_out  <= dest;
			op_type_out  <= op_type;
			alu_func_out <= alu_func;
			rob_idx_out  <= rob_idx;
			class_out    <= fu_class;
		end else if (state == entry_waiting) begin
			opa_q <= opa_snoop; // Unchanged unless a tag matched
			opb_q <= opb_snoop;
		end
	end

	assign free    = (state == entry_free);
	assign ready   = (state == entry_ready);
	assign opa_out = opa_q;
	assign opb_out = opb_q;

endmodule

// File: hw/rs_free_finder.sv
`timescale 1ns/100ps
/* Lowest two free slots as one-hot vectors, zero when none is left */
module rs_free_finder import rs_pkg::*; (
	input  rs_vec_t  free_vec,
	output rs_vec_t  grant_first,
	output rs_vec_t  grant_second,
	output rs_full_t rs_full
);

	rs_vec_t rest;

	// Two's complement isolates the lowest set bit
	assign grant_first  = free_vec & -free_vec;
	assign rest         = free_vec & ~grant_first;
	assign grant_second = rest & -rest;

	always_comb begin
		if (|grant_second)
			rs_full = two_or_more_empty;
		else if (|grant_first)
			rs_full = one_entry_empty;
		else
			rs_full = no_entry_empty;
	end

endmodule

// File: hw/rs_entry_array.sv
`timescale 1ns/100ps
/* Eight slots and their allocator. inst2 always aims at the second-lowest free slot;
   a load that finds no slot is dropped. */
module rs_entry_array import rs_pkg::*; (
	input  logic                     clock,
	input  logic                     arst_n,
	input  logic                     inst1_load,
	input  logic                     inst2_load,
	input  word_t                    inst1_opa_fwd,
	input  logic                     inst1_opa_fwd_valid,
	input  word_t                    inst1_opb_fwd,
	input  logic                     inst1_opb_fwd_valid,
	input  fu_class_t                inst1_class,
	input  prf_tag_t                 inst1_dest,
	input  op_type_t                 inst1_op_type,
	input  alu_func_t                inst1_alu_func,
	input  rob_idx_t                 inst1_rob_idx,
	input  word_t                    inst2_opa_fwd,
	input  logic                     inst2_opa_fwd_valid,
	input  word_t                    inst2_opb_fwd,
	input  logic                     inst2_opb_fwd_valid,
	input  fu_class_t                inst2_class,
	input  prf_tag_t                 inst2_dest,
	input  op_type_t                 inst2_op_type,
	input  alu_func_t                inst2_alu_func,
	input  rob_idx_t                 inst2_rob_idx,
	input  logic                     cdb1_valid,
	input  prf_tag_t                 cdb1_tag,
	input  word_t                    cdb1_value,
	input  logic                     cdb2_valid,
	input  prf_tag_t                 cdb2_tag,
	input  word_t                    cdb2_value,
	input  rs_vec_t [FU_PORTS-1:0]   slot_issue,
	output rs_vec_t                  slot_ready,
	output fu_class_t [RS_SIZE-1:0]  slot_class,
	output word_t [RS_SIZE-1:0]      slot_opa,
	output word_t [RS_SIZE-1:0]      slot_opb,
	output prf_tag_t [RS_SIZE-1:0]   slot_dest,
	output rob_idx_t [RS_SIZE-1:0]   slot_rob_idx,
	output op_type_t [RS_SIZE-1:0]   slot_op_type,
	output alu_func_t [RS_SIZE-1:0]  slot_alu_func,
	output rs_full_t                 rs_full
);

	rs_vec_t free_vec;
	rs_vec_t grant_first;
	rs_vec_t grant_second;
	rs_vec_t load1;
	rs_vec_t load2;
	rs_vec_t issue_vec;

	rs_free_finder u_finder (
		.free_vec     (free_vec),
		.grant_first  (grant_first),
		.grant_second (grant_second),
		.rs_full      (rs_full)
	);

	assign load1 = grant_first & {RS_SIZE{inst1_load}};
	assign load2 = grant_second & {RS_SIZE{inst2_load}};

	// A slot is freed when any port took it
	always_comb begin
		issue_vec = '0;
		for (int p = 0; p < FU_PORTS; p++)
			issue_vec |= slot_issue[p];
	end

	for (genvar i = 0; i < RS_SIZE; i++) begin : g_slot
		rs_entry u_entry (
			.clock        (clock),
			.arst_n       (arst_n),
			.load         (load1[i] | load2[i]),
			.opa          (load2[i] ? inst2_opa_fwd : inst1_opa_fwd),
			.opa_valid    (load2[i] ? inst2_opa_fwd_valid : inst1_opa_fwd_valid),
			.opb          (load2[i] ? inst2_opb_fwd : inst1_opb_fwd),
			.opb_valid    (load2[i] ? inst2_opb_fwd_valid : inst1_opb_fwd_valid),
			.dest         (load2[i] ? inst2_dest : inst1_dest),
			.op_type      (load2[i] ? inst2_op_type : inst1_op_type),
			.alu_func     (load2[i] ? inst2_alu_func : inst1_alu_func),
			.rob_idx      (load2[i] ? inst2_rob_idx : inst1_rob_idx),
			.fu_class     (load2[i] ? inst2_class : inst1_class),
			.issue        (issue_vec[i]),
			.cdb1_valid   (cdb1_valid),
			.cdb1_tag     (cdb1_tag),
			.cdb1_value   (cdb1_value),
			.cdb2_valid   (cdb2_valid),
			.cdb2_tag     (cdb2_tag),
			.cdb2_value   (cdb2_value),
			.free         (free_vec[i]),
			.ready        (slot_ready[i]),
			.opa_out      (slot_opa[i]),
			.opb_out      (slot_opb[i]),
			.dest_out     (slot_dest[i]),
			.op_type_out  (slot_op_type[i]),
			.alu_func_out (slot_alu_func[i]),
			.rob_idx_out  (slot_rob_idx[i]),
			.class_out    (slot_class[i])
		);
	end

endmodule

// File: hw/rs_issue_select.sv
`timescale 1ns/100ps
/* Fixed port order 0 to 5, lowest ready slot first. Idle ports drive zero with alu_default. */
module rs_issue_select import rs_pkg::*; (
	input  logic [FU_PORTS-1:0]       fu_available,
	input  rs_vec_t                   slot_ready,
	input  fu_class_t [RS_SIZE-1:0]   slot_class,
	input  word_t [RS_SIZE-1:0]       slot_opa,
	input  word_t [RS_SIZE-1:0]       slot_opb,
	input  prf_tag_t [RS_SIZE-1:0]    slot_dest,
	input  rob_idx_t [RS_SIZE-1:0]    slot_rob_idx,
	input  op_type_t [RS_SIZE-1:0]    slot_op_type,
	input  alu_func_t [RS_SIZE-1:0]   slot_alu_func,
	output rs_vec_t [FU_PORTS-1:0]    slot_issue,
	output logic [FU_PORTS-1:0]       fu_valid,
	output word_t [FU_PORTS-1:0]      fu_opa,
	output word_t [FU_PORTS-1:0]      fu_opb,
	output prf_tag_t [FU_PORTS-1:0]   fu_dest,
	output rob_idx_t [FU_PORTS-1:0]   fu_rob_idx,
	output op_type_t [FU_PORTS-1:0]   fu_op_type,
	output alu_func_t [FU_PORTS-1:0]  fu_alu_func
);

	rs_vec_t taken; // Slots claimed by earlier ports
	logic    found;

	always_comb begin
		taken = '0;
		for (int p = 0; p < FU_PORTS; p++) begin
			slot_issue[p]  = '0;
			fu_valid[p]    = 1'b0;
			fu_opa[p]      = '0;
			fu_opb[p]      = '0;
			fu_dest[p]     = '0;
			fu_rob_idx[p]  = '0;
			fu_op_type[p]  = '0;
			fu_alu_func[p] = alu_default;
			found          = 1'b0;
			for (int i = 0; i < RS_SIZE; i++) begin
				if (!found && fu_available[p] && slot_ready[i] && !taken[i] &&
				    slot_class[i] == PORT_CLASS[p]) begin
					found            = 1'b1;
					taken[i]         = 1'b1;
					slot_issue[p][i] = 1'b1;
					fu_valid[p]      = 1'b1;
					fu_opa[p]        = slot_opa[i];
					fu_opb[p]        = slot_opb[i];
					fu_dest[p]       = slot_dest[i];
					fu_rob_idx[p]    = slot_rob_idx[i];
					fu_op_type[p]    = slot_op_type[i];
					fu_alu_func[p]   = slot_alu_func[i];
				end
			end
		end
	end

endmodule

// File: hw/rs_top.sv
`timescale 1ns/100ps
/* Two-wide dispatch, two CDBs, six issue ports. The caller must not load past rs_full;
   fu_available orders ports mult1, adder1, memory1, mult2, adder2, memory2. */
module rs_top import rs_pkg::*; (
	input  logic                      clock,
	input  logic                      arst_n,
	input  logic                      inst1_load,
	input  word_t                     inst1_opa,
	input  logic                      inst1_opa_valid,
	input  word_t                     inst1_opb,
	input  logic                      inst1_opb_valid,
	input  prf_tag_t                  inst1_dest,
	input  op_type_t                  inst1_op_type,
	input  alu_func_t                 inst1_alu_func,
	input  rob_idx_t                  inst1_rob_idx,
	input  logic                      inst2_load,
	input  word_t                     inst2_opa,
	input  logic                      inst2_opa_valid,
	input  word_t                     inst2_opb,
	input  logic                      inst2_opb_valid,
	input  prf_tag_t                  inst2_dest,
	input  op_type_t                  inst2_op_type,
	input  alu_func_t                 inst2_alu_func,
	input  rob_idx_t                  inst2_rob_idx,
	input  logic                      cdb1_valid,
	input  prf_tag_t                  cdb1_tag,
	input  word_t                     cdb1_value,
	input  logic                      cdb2_valid,
	input  prf_tag_t                  cdb2_tag,
	input  word_t                     cdb2_value,
	input  logic [FU_PORTS-1:0]       fu_available,
	output logic [FU_PORTS-1:0]       fu_valid,
	output word_t [FU_PORTS-1:0]      fu_opa,
	output word_t [FU_PORTS-1:0]      fu_opb,
	output prf_tag_t [FU_PORTS-1:0]   fu_dest,
	output rob_idx_t [FU_PORTS-1:0]   fu_rob_idx,
	output op_type_t [FU_PORTS-1:0]   fu_op_type,
	output alu_func_t [FU_PORTS-1:0]  fu_alu_func,
	output rs_full_t                  rs_full
);

	////////////////////////////////////////////////////////////
	// Dispatch bypass to entry array
	////////////////////////////////////////////////////////////
	word_t     inst1_opa_fwd;
	logic      inst1_opa_fwd_valid;
	word_t     inst1_opb_fwd;
	logic      inst1_opb_fwd_valid;
	fu_class_t inst1_class;
	word_t     inst2_opa_fwd;
	logic      inst2_opa_fwd_valid;
	word_t     inst2_opb_fwd;
	logic      inst2_opb_fwd_valid;
	fu_class_t inst2_class;

	////////////////////////////////////////////////////////////
	// Entry array to issue select and back
	////////////////////////////////////////////////////////////
	rs_vec_t                  slot_ready;
	fu_class_t [RS_SIZE-1:0]  slot_class;
	word_t [RS_SIZE-1:0]      slot_opa;
	word_t [RS_SIZE-1:0]      slot_opb;
	prf_tag_t [RS_SIZE-1:0]   slot_dest;
	rob_idx_t [RS_SIZE-1:0]   slot_rob_idx;
	op_type_t [RS_SIZE-1:0]   slot_op_type;
	alu_func_t [RS_SIZE-1:0]  slot_alu_func;
	rs_vec_t [FU_PORTS-1:0]   slot_issue; // One set of slots per port

	// Port and net names match across the stages
	rs_dispatch_bypass u_bypass (.*);

	rs_entry_array u_array (.*);

	rs_issue_select u_select (.*);

endmodule

// File: testbench/rs_tb.sv
`timescale 1ns/100ps
/* Random dispatch, wakeup and availability against a slot model kept from the station rules.
   Tags are drawn from a small set so that CDB matches happen often. */
module rs_tb import rs_pkg::*;;

	localparam int RESET_CYCLES = 16;
	localparam int FILL_CYCLES  = 30;  // Units held off while the station fills up
	localparam int MIX_CYCLES   = 400;
	localparam int DRAIN_CYCLES = 80;
	localparam int TOTAL_CYCLES = RESET_CYCLES + FILL_CYCLES + MIX_CYCLES + DRAIN_CYCLES;

	logic clock, arst_n;
	logic inst1_load, inst1_opa_valid, inst1_opb_valid;
	logic inst2_load, inst2_opa_valid, inst2_opb_valid;
	word_t inst1_opa, inst1_opb, inst2_opa, inst2_opb;
	prf_tag_t inst1_dest, inst2_dest;
	op_type_t inst1_op_type, inst2_op_type;
	alu_func_t inst1_alu_func, inst2_alu_func;
	rob_idx_t inst1_rob_idx, inst2_rob_idx;
	logic cdb1_valid, cdb2_valid;
	prf_tag_t cdb1_tag, cdb2_tag;
	word_t cdb1_value, cdb2_value;
	logic [FU_PORTS-1:0] fu_available, fu_valid;
	word_t [FU_PORTS-1:0] fu_opa, fu_opb;
	prf_tag_t [FU_PORTS-1:0] fu_dest;
	rob_idx_t [FU_PORTS-1:0] fu_rob_idx;
	op_type_t [FU_PORTS-1:0] fu_op_type;
	alu_func_t [FU_PORTS-1:0] fu_alu_func;
	rs_full_t rs_full;

	int errors = 0;
	int issued = 0;
	logic [31:0] lfsr = 32'h3138;

	rs_top u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] r = '0;
		for (int k = 0; k < n; k++) begin
			r[k] = lfsr[0];
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model of the slots
	////////////////////////////////////////////////////////////
	rs_entry_state_t m_state [RS_SIZE];
	word_t m_opa [RS_SIZE], m_opb [RS_SIZE];
	logic m_opa_v [RS_SIZE], m_opb_v [RS_SIZE];
	prf_tag_t m_dest [RS_SIZE];
	op_type_t m_op_type [RS_SIZE];
	alu_func_t m_alu [RS_SIZE];
	rob_idx_t m_rob [RS_SIZE];
	fu_class_t m_class [RS_SIZE];

	logic [FU_PORTS-1:0] exp_valid;
	logic [FU_PORTS-1:0][WORD_W*2+TAG_W+ROB_W+OP_TYPE_W+5-1:0] exp_fields;
	rs_vec_t exp_freed;
	rs_full_t exp_full;

	// CDB1 checked before CDB2
	function automatic logic [WORD_W:0] fill(word_t op, logic v);
		if (!v && cdb1_valid && cdb1_tag == op[TAG_W-1:0]) return {1'b1, cdb1_value};
		if (!v && cdb2_valid && cdb2_tag == op[TAG_W-1:0]) return {1'b1, cdb2_value};
		return {v, op};
	endfunction

	function automatic fu_class_t unit_of(op_type_t t, alu_func_t f);
		if (t[5:3] == 3'd2 && f == alu_mulq) return use_multiplier;
		if (t[5:3] == 3'd4 || t[5:3] == 3'd5) return use_memory;
		return use_adder;
	endfunction

	function automatic fu_class_t port_unit(int p);
		case (p % 3)
			0: return use_multiplier;
			1: return use_adder;
			default: return use_memory;
		endcase
	endfunction

	always_comb begin
		int nfree;
		logic found;
		exp_freed = '0;
		nfree = 0;
		for (int i = 0; i < RS_SIZE; i++)
			if (m_state[i] == entry_free) nfree++;
		exp_full = nfree >= 2 ? two_or_more_empty : (nfree == 1 ? one_entry_empty : no_entry_empty);
		for (int p = 0; p < FU_PORTS; p++) begin
			exp_valid[p] = 1'b0;
			exp_fields[p] = {128'd0, 6'd0, 5'd0, 6'd0, alu_default};
			found = 1'b0;
			for (int i = 0; i < RS_SIZE; i++) begin
				if (!found && fu_available[p] && m_state[i] == entry_ready && !exp_freed[i] &&
				    m_class[i] == port_unit(p)) begin
					found = 1'b1;
					exp_freed[i] = 1'b1;
					exp_valid[p] = 1'b1;
					exp_fields[p] = {m_opa[i], m_opb[i], m_dest[i], m_rob[i], m_op_type[i], m_alu[i]};
				end
			end
		end
	end

	always @(posedge clock or negedge arst_n) begin
		logic [WORD_W:0] a, b;
		int first, second;
		if (!arst_n) begin
			for (int i = 0; i < RS_SIZE; i++) m_state[i] <= entry_free;
		end else begin
			first = -1;
			second = -1;
			for (int i = 0; i < RS_SIZE; i++) begin
				if (m_state[i] == entry_free) begin
					if (first < 0) first = i;
					else if (second < 0) second = i;
				end else if (m_state[i] == entry_waiting) begin
					a = fill(m_opa[i], m_opa_v[i]);
					b = fill(m_opb[i], m_opb_v[i]);
					{m_opa_v[i], m_opa[i]} <= a;
					{m_opb_v[i], m_opb[i]} <= b;
					if (a[WORD_W] && b[WORD_W]) m_state[i] <= entry_ready;
				end else if (exp_freed[i]) begin
					m_state[i] <= entry_free;
					issued++;
				end
			end
			// Loads without a slot are dropped
			if (inst1_load && first >= 0) begin
				a = fill(inst1_opa, inst1_opa_valid);
				b = fill(inst1_opb, inst1_opb_valid);
				{m_opa_v[first], m_opa[first]} <= a;
				{m_opb_v[first], m_opb[first]} <= b;
				m_state[first] <= (a[WORD_W] && b[WORD_W]) ? entry_ready : entry_waiting;
				m_dest[first] <= inst1_dest;
				m_op_type[first] <= inst1_op_type;
				m_alu[first] <= inst1_alu_func;
				m_rob[first] <= inst1_rob_idx;
				m_class[first] <= unit_of(inst1_op_type, inst1_alu_func);
			end
			if (inst2_load && second >= 0) begin
				a = fill(inst2_opa, inst2_opa_valid);
				b = fill(inst2_opb, inst2_opb_valid);
				{m_opa_v[second], m_opa[second]} <= a;
				{m_opb_v[second], m_opb[second]} <= b;
				m_state[second] <= (a[WORD_W] && b[WORD_W]) ? entry_ready : entry_waiting;
				m_dest[second] <= inst2_dest;
				m_op_type[second] <= inst2_op_type;
				m_alu[second] <= inst2_alu_func;
				m_rob[second] <= inst2_rob_idx;
				m_class[second] <= unit_of(inst2_op_type, inst2_alu_func);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks sampled on the falling edge
	////////////////////////////////////////////////////////////
	for (genvar p = 0; p < FU_PORTS; p++) begin : g_port_check
		assert property (@(negedge clock) disable iff (!arst_n)
			fu_valid[p] == exp_valid[p] &&
			{fu_opa[p], fu_opb[p], fu_dest[p], fu_rob_idx[p], fu_op_type[p], fu_alu_func[p]}
				== exp_fields[p])
		else begin
			errors++;
			$display("Error %0d ns: port %0d issued wrong valid or fields", $time, p);
		end
	end

	assert property (@(negedge clock) disable iff (!arst_n) rs_full == exp_full)
	else begin
		errors++;
		$display("Error %0d ns: rs_full is %0d, expected %0d", $time, rs_full, exp_full);
	end

	// Drives one cycle of dispatch and CDB traffic
	task automatic drive_cycle(logic loads_on, logic [FU_PORTS-1:0] avail);
		logic [2:0] g1, g2;
		@(posedge clock);
		g1 = rand_bits(1) ? 3'd2 : (rand_bits(1) ? 3'd4 : 3'(rand_bits(3)));
		g2 = rand_bits(1) ? 3'd2 : (rand_bits(1) ? 3'd5 : 3'(rand_bits(3)));
		inst1_load <= loads_on & 1'(rand_bits(1));
		inst2_load <= loads_on & 1'(rand_bits(1));
		inst1_opa <= {58'(rand_bits(58)), 6'(rand_bits(3))};
		inst1_opb <= {58'(rand_bits(58)), 6'(rand_bits(3))};
		inst2_opa <= {58'(rand_bits(58)), 6'(rand_bits(3))};
		inst2_opb <= {58'(rand_bits(58)), 6'(rand_bits(3))};
		inst1_opa_valid <= 1'(rand_bits(1));
		inst1_opb_valid <= 1'(rand_bits(1));
		inst2_opa_valid <= 1'(rand_bits(1));
		inst2_opb_valid <= 1'(rand_bits(1));
		inst1_dest <= prf_tag_t'(rand_bits(6));
		inst2_dest <= prf_tag_t'(rand_bits(6));
		inst1_op_type <= {g1, 3'(rand_bits(3))};
		inst2_op_type <= {g2, 3'(rand_bits(3))};
		inst1_alu_func <= rand_bits(1) ? alu_mulq : alu_addq;
		inst2_alu_func <= rand_bits(1) ? alu_mulq : alu_xor;
		inst1_rob_idx <= rob_idx_t'(rand_bits(5));
		inst2_rob_idx <= rob_idx_t'(rand_bits(5));
		cdb1_valid <= 1'(rand_bits(1));
		cdb2_valid <= 1'(rand_bits(1));
		cdb1_tag <= prf_tag_t'(rand_bits(3)); // Small tag set for frequent matches
		cdb2_tag <= prf_tag_t'(rand_bits(3));
		cdb1_value <= rand_bits(64);
		cdb2_value <= rand_bits(64);
		fu_available <= avail;
	endtask

	initial begin
		arst_n = 1'b0;
		{inst1_load, inst2_load, inst1_opa_valid, inst1_opb_valid} = '0;
		{inst2_opa_valid, inst2_opb_valid, cdb1_valid, cdb2_valid} = '0;
		{inst1_opa, inst1_opb, inst2_opa, inst2_opb, cdb1_value, cdb2_value} = '0;
		{inst1_dest, inst2_dest, cdb1_tag, cdb2_tag} = '0;
		{inst1_op_type, inst2_op_type, inst1_rob_idx, inst2_rob_idx} = '0;
		inst1_alu_func = alu_default;
		inst2_alu_func = alu_default;
		fu_available = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		arst_n <= 1'b1;
		repeat (FILL_CYCLES) drive_cycle(1'b1, '0);
		for (int c = 0; c < MIX_CYCLES; c++)
			drive_cycle(1'b1, (c / 40) % 3 == 1 ? 6'(rand_bits(6)) : 6'(rand_bits(6) | rand_bits(6)));
		repeat (DRAIN_CYCLES) drive_cycle(1'b0, '1);
		@(negedge clock);
		$display("Closing report: %0d errors, %0d instructions issued", errors, issued);
		if (errors == 0 && issued > 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#((TOTAL_CYCLES + 50) * 100);
		$display("Watchdog expired before the test sequence finished");
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: filelist.f
hw/rs_pkg.sv
hw/rs_dispatch_bypass.sv
hw/rs_entry.sv
hw/rs_free_finder.sv
hw/rs_entry_array.sv
hw/rs_issue_select.sv
hw/rs_top.sv
testbench/rs_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the reservation station testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module rs_tb -f filelist.f -o rs_sim

./obj_dir/rs_sim > sim.log
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
